// File: src/mon_params.svh
`ifndef MON_PARAMS_SVH
`define MON_PARAMS_SVH

////////////////////////////////////////////////////////////////////////////
// Trace store geometry
////////////////////////////////////////////////////////////////////////////

// Slots in the capture buffer
`define MON_DEPTH   16
// Hex digits printed per trace word
`define MON_NIBBLES 8

////////////////////////////////////////////////////////////////////////////
// Console characters
////////////////////////////////////////////////////////////////////////////

`define CMD_DEC    8'h31
`define CMD_INC    8'h32
`define CMD_DUMP   8'h20
`define CHAR_SPACE 8'h20

////////////////////////////////////////////////////////////////////////////
// Baud divisors indexed by br_cfg
////////////////////////////////////////////////////////////////////////////

`define DIV_4800  16'h12C0
`define DIV_9600  16'h2580
`define DIV_19200 16'h4B00
`define DIV_38400 16'h9600

`endif

// File: src/mon_pkg.sv
`default_nettype none

package mon_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Data types on the SPART side and in the trace store
	////////////////////////////////////////////////////////////////////////////
	typedef logic [7:0]  byte_t;
	typedef logic [31:0] word_t;
	typedef logic [3:0]  slot_t;

	// SPART register map
	typedef enum logic [1:0] {
		IO_DATA   = 2'd0,
		IO_STATUS = 2'd1,
		IO_DIV_LO = 2'd2,
		IO_DIV_HI = 2'd3
	} io_addr_t;

	// Console monitor states
	typedef enum logic [3:0] {
		RESET_IDLE    = 4'd0,
		INIT_LOW_DIV  = 4'd1,
		INIT_HIGH_DIV = 4'd2,
		RECEIVE_WAIT  = 4'd3,
		ECHO_SLOT     = 4'd4,
		ECHO_SPACE    = 4'd5,
		SEND_LONG_HEX = 4'd6,
		SEND_SPACE    = 4'd7
	} mon_state_t;

	// One nibble to its upper-case ASCII hex digit
	function automatic byte_t hex_to_ascii(input logic [3:0] nib);
		if (nib < 4'd10)
			return 8'h30 + {4'h0, nib};
		return 8'h37 + {4'h0, nib};
	endfunction

endpackage

`default_nettype wire

// File: src/trace_buffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "mon_params.svh"

module trace_buffer (
	input  logic           clk,
	input  logic           rst,
	input  mon_pkg::word_t probe,
	input  logic           probe_valid,
	input  mon_pkg::slot_t rd_slot,
	output mon_pkg::word_t rd_word
);

	import mon_pkg::*;

	localparam int IDX_W = $clog2(`MON_DEPTH);
	// One extra bit so a full buffer is distinguishable from an empty one
	localparam int CNT_W = IDX_W + 1;

	word_t            mem [`MON_DEPTH];
	logic [CNT_W-1:0] fill_cnt;
	logic             full;

	assign full = (fill_cnt == CNT_W'(`MON_DEPTH));

	////////////////////////////////////////////////////////////////////////////
	// Capture side
	////////////////////////////////////////////////////////////////////////////

	// Slots fill in order and stay frozen once all are taken
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			fill_cnt <= '0;
			for (int i = 0; i < `MON_DEPTH; i++) begin
				mem[i] <= '0;
			end
		end else if (probe_valid && !full) begin
			mem[fill_cnt[IDX_W-1:0]] <= probe;
			fill_cnt <= fill_cnt + 1'b1;
		end
	end

	// Readout for the dump
	assign rd_word = mem[rd_slot];

endmodule

`default_nettype wire

// File: src/hex_serializer.sv
`timescale 1ns/1ps
`default_nettype none

`include "mon_params.svh"

module hex_serializer (
	input  logic           clk,
	input  logic           rst,
	input  mon_pkg::word_t word,
	input  logic           load,
	input  logic           step,
	output mon_pkg::byte_t hex_char,
	output logic           hex_last
);

	import mon_pkg::*;

	localparam int IDX_W = $clog2(`MON_NIBBLES);

	logic [IDX_W-1:0] idx;
	logic [3:0]       nib;

	////////////////////////////////////////////////////////////////////////////
	// Nibble index
	////////////////////////////////////////////////////////////////////////////

	// Load starts at the top nibble, step walks toward bit 0
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			idx <= '0;
		end else if (load) begin
			idx <= IDX_W'(`MON_NIBBLES - 1);
		end else if (step) begin
			idx <= idx - 1'b1;
		end
	end

	// Indexed nibble of the current word
	assign nib = word[{idx, 2'b00} +: 4];

	assign hex_char = hex_to_ascii(nib);

	// Lowest nibble ends the word
	assign hex_last = (idx == '0);

endmodule

`default_nettype wire

// File: src/monitor_fsm.sv
`timescale 1ns/1ps
`default_nettype none

`include "mon_params.svh"

module monitor_fsm (
	input  logic              clk,
	input  logic              rst,
	input  logic [1:0]        br_cfg,
	input  logic              rda,
	input  logic              tbr,
	input  mon_pkg::byte_t    db_rd_data,
	output logic              iocs,
	output logic              iorw,
	output mon_pkg::io_addr_t ioaddr,
	output mon_pkg::byte_t    db_wr_data,
	output logic              db_drive,
	output mon_pkg::slot_t    slot,
	input  mon_pkg::byte_t    hex_char,
	input  logic              hex_last,
	output logic              hex_load,
	output logic              hex_step
);

	import mon_pkg::*;

	mon_state_t  state;
	mon_state_t  state_nxt;
	slot_t       slot_ptr;
	slot_t       slot_nxt;
	logic [15:0] div_word;

	// Divisor for the selected baud rate
	always_comb begin
		case (br_cfg)
			2'd0:    div_word = `DIV_4800;
			2'd1:    div_word = `DIV_9600;
			2'd2:    div_word = `DIV_19200;
			default: div_word = `DIV_38400;
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// State and slot pointer registers
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state    <= RESET_IDLE;
			slot_ptr <= '0;
		end else begin
			state    <= state_nxt;
			slot_ptr <= slot_nxt;
		end
	end

	assign slot = slot_ptr;

	////////////////////////////////////////////////////////////////////////////
	// Next state and bus access
	////////////////////////////////////////////////////////////////////////////

	// Idle bus by default, transmit states wait on tbr with iocs low
	always_comb begin
		state_nxt  = state;
		slot_nxt   = slot_ptr;
		iocs       = 1'b0;
		iorw       = 1'b1;
		ioaddr     = IO_DATA;
		db_wr_data = 8'h00;
		hex_load   = 1'b0;
		hex_step   = 1'b0;

		case (state)
			RESET_IDLE: begin
				state_nxt = INIT_LOW_DIV;
			end

			// Divisor setup does not wait for the transmitter
			INIT_LOW_DIV: begin
				iocs       = 1'b1;
				iorw       = 1'b0;
				ioaddr     = IO_DIV_LO;
				db_wr_data = div_word[7:0];
				state_nxt  = INIT_HIGH_DIV;
			end

			INIT_HIGH_DIV: begin
				iocs       = 1'b1;
				iorw       = 1'b0;
				ioaddr     = IO_DIV_HI;
				db_wr_data = div_word[15:8];
				state_nxt  = RECEIVE_WAIT;
			end

			// Poll the data register, a byte with rda high is consumed here
			RECEIVE_WAIT: begin
				iocs = 1'b1;
				if (rda) begin
					case (db_rd_data)
						`CMD_DEC: begin
							slot_nxt  = slot_ptr - 1'b1;
							state_nxt = ECHO_SLOT;
						end
						`CMD_INC: begin
							slot_nxt  = slot_ptr + 1'b1;
							state_nxt = ECHO_SLOT;
						end
						`CMD_DUMP: begin
							slot_nxt  = '0;
							hex_load  = 1'b1;
							state_nxt = SEND_LONG_HEX;
						end
						default: state_nxt = RECEIVE_WAIT;
					endcase
				end
			end

			ECHO_SLOT: begin
				if (tbr) begin
					iocs       = 1'b1;
					iorw       = 1'b0;
					db_wr_data = hex_to_ascii(slot_ptr);
					state_nxt  = ECHO_SPACE;
				end
			end

			ECHO_SPACE: begin
				if (tbr) begin
					iocs       = 1'b1;
					iorw       = 1'b0;
					db_wr_data = `CHAR_SPACE;
					state_nxt  = RECEIVE_WAIT;
				end
			end

			// One digit per accepted write, top nibble first
			SEND_LONG_HEX: begin
				if (tbr) begin
					iocs       = 1'b1;
					iorw       = 1'b0;
					db_wr_data = hex_char;
					if (hex_last)
						state_nxt = SEND_SPACE;
					else
						hex_step = 1'b1;
				end
			end

			// Separator, then the next slot or back to polling
			SEND_SPACE: begin
				if (tbr) begin
					iocs       = 1'b1;
					iorw       = 1'b0;
					db_wr_data = `CHAR_SPACE;
					if (slot_ptr == slot_t'(`MON_DEPTH - 1)) begin
						state_nxt = RECEIVE_WAIT;
					end else begin
						slot_nxt  = slot_ptr + 1'b1;
						hex_load  = 1'b1;
						state_nxt = SEND_LONG_HEX;
					end
				end
			end

			default: state_nxt = RESET_IDLE;
		endcase
	end

	// The driver owns the data lines only during writes
	assign db_drive = iocs & ~iorw;

endmodule

`default_nettype wire

// File: src/spart_driver.sv
`timescale 1ns/1ps
`default_nettype none

module spart_driver (
	input  logic              clk,
	input  logic              rst,
	input  logic [1:0]        br_cfg,
	input  logic              rda,
	input  logic              tbr,
	input  mon_pkg::byte_t    db_rd_data,
	input  mon_pkg::word_t    probe,
	input  logic              probe_valid,
	output logic              iocs,
	output logic              iorw,
	output mon_pkg::io_addr_t ioaddr,
	output mon_pkg::byte_t    db_wr_data,
	output logic              db_drive
);

	import mon_pkg::*;

	word_t rd_word;
	slot_t slot;
	byte_t hex_char;
	logic  hex_last;
	logic  hex_load;
	logic  hex_step;

	////////////////////////////////////////////////////////////////////////////
	// Capture store and word formatter
	////////////////////////////////////////////////////////////////////////////

	trace_buffer u_trace_buffer (
		.clk        (clk),
		.rst        (rst),
		.probe      (probe),
		.probe_valid(probe_valid),
		.rd_slot    (slot),
		.rd_word    (rd_word)
	);

	hex_serializer u_hex_serializer (
		.clk     (clk),
		.rst     (rst),
		.word    (rd_word),
		.load    (hex_load),
		.step    (hex_step),
		.hex_char(hex_char),
		.hex_last(hex_last)
	);

	// Console control and SPART bus
	monitor_fsm u_monitor_fsm (
		.clk       (clk),
		.rst       (rst),
		.br_cfg    (br_cfg),
		.rda       (rda),
		.tbr       (tbr),
		.db_rd_data(db_rd_data),
		.iocs      (iocs),
		.iorw      (iorw),
		.ioaddr    (ioaddr),
		.db_wr_data(db_wr_data),
		.db_drive  (db_drive),
		.slot      (slot),
		.hex_char  (hex_char),
		.hex_last  (hex_last),
		.hex_load  (hex_load),
		.hex_step  (hex_step)
	);

endmodule

`default_nettype wire

// File: sim/spart_bus_model.sv
`timescale 1ns/1ps
`default_nettype none

module spart_bus_model (
	input  logic              clk,
	input  logic              rst,
	input  logic              iocs,
	input  logic              iorw,
	input  mon_pkg::io_addr_t ioaddr,
	input  mon_pkg::byte_t    db_wr_data,
	input  logic              cmd_valid,
	input  mon_pkg::byte_t    cmd_byte,
	output logic              rda,
	output logic              tbr,
	output mon_pkg::byte_t    db_rd_data,
	output logic              wr_seen,
	output mon_pkg::io_addr_t wr_addr,
	output mon_pkg::byte_t    wr_data
);

	import mon_pkg::*;

	integer   seed;
	int       busy;
	byte_t    rx_q[$];
	logic     clr;
	logic     take;
	logic     wr;
	logic     push;
	io_addr_t addr_s;
	byte_t    data_s;
	byte_t    cmd_s;

	////////////////////////////////////////////////////////////////////////////
	// Sample the bus mid cycle, update the SPART side 2 ns after the edge
	////////////////////////////////////////////////////////////////////////////

	initial begin
		seed       = 32'ha7961363;
		busy       = 0;
		rda        = 1'b0;
		tbr        = 1'b1;
		db_rd_data = 8'h00;
		wr_seen    = 1'b0;
		wr_addr    = IO_DATA;
		wr_data    = 8'h00;
		forever begin
			@(negedge clk);
			clr    = rst;
			take   = iocs && iorw && (ioaddr == IO_DATA) && rda;
			wr     = iocs && !iorw;
			push   = cmd_valid;
			addr_s = ioaddr;
			data_s = db_wr_data;
			cmd_s  = cmd_byte;
			@(posedge clk);
			#2;
			if (clr)
				rx_q.delete();
			if (take)
				void'(rx_q.pop_front());
			if (push)
				rx_q.push_back(cmd_s);
			// Transmitter stays busy 0 to 3 cycles after each data byte
			if (wr && addr_s == IO_DATA)
				busy = $random(seed) & 3;
			else if (busy > 0)
				busy--;
			tbr        = (busy == 0);
			rda        = (rx_q.size() != 0);
			db_rd_data = (rx_q.size() != 0) ? rx_q[0] : 8'h00;
			wr_seen    = wr;
			wr_addr    = addr_s;
			wr_data    = data_s;
		end
	end

endmodule

`default_nettype wire

// File: sim/tb_spart_driver.sv
`timescale 1ns/1ps
`default_nettype none

module tb_spart_driver;

	import mon_pkg::*;

	logic        clk;
	logic        rst;
	logic [1:0]  br_cfg;
	word_t       probe;
	logic        probe_valid;
	logic        rda;
	logic        tbr;
	byte_t       db_rd_data;
	logic        iocs;
	logic        iorw;
	io_addr_t    ioaddr;
	byte_t       db_wr_data;
	logic        db_drive;
	logic        cmd_valid;
	byte_t       cmd_byte;
	logic        wr_seen;
	io_addr_t    wr_addr;
	byte_t       wr_data;

	// Parsed stimulus records and the expected writes, {addr, byte}
	byte_t       rec_kind[$];
	logic [31:0] rec_a[$];
	logic [31:0] rec_b[$];
	logic [31:0] rec_c[$];
	string       rec_txt[$];
	logic [9:0]  exp_q[$];
	int          cycles = 0;
	int          limit = 0;

	spart_driver u_spart_driver (.*);

	spart_bus_model u_bus_model (.*);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic abort_run();
		$display("Result: FAILED");
		$fatal(1, "Simulation stopped on error");
	endtask

	task automatic check_value(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp) begin
			$display("[FAIL] %0t ns: %s = %h, expected %h", $time, name, got, exp);
			abort_run();
		end
	endtask

	task automatic load_records();
		int          fd;
		int          n;
		string       line;
		string       kind;
		string       txt;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] c;
		fd = $fopen("sim/spart_stimulus.txt", "r");
		if (fd == 0) begin
			$display("Cannot open the stimulus file sim/spart_stimulus.txt");
			abort_run();
		end
		limit = 200;
		while ($fgets(line, fd) > 0) begin
			b   = 1;
			c   = 0;
			txt = "";
			if ($sscanf(line, "%s", kind) != 1 || kind == "#")
				continue;
			case (kind)
				"R": n = $sscanf(line, "%s %h %h %h", kind, a, b, c);
				"P": n = $sscanf(line, "%s %h %d", kind, a, b);
				"C": n = $sscanf(line, "%s %h", kind, a);
				"X": n = $sscanf(line, "%s %h %s %d", kind, a, txt, b);
				default: begin
					$display("Unknown record kind in stimulus line: %s", line);
					abort_run();
				end
			endcase
			// Eight cycles per expected byte plus twenty per record
			limit += 20;
			if (kind == "R")
				limit += 16;
			if (kind == "X")
				limit += 8 * txt.len() * b;
			rec_kind.push_back(kind[0]);
			rec_a.push_back(a);
			rec_b.push_back(b);
			rec_c.push_back(c);
			rec_txt.push_back(txt);
		end
		$fclose(fd);
	endtask

	// Monitor back at the receive poll with nothing pending
	task automatic wait_idle();
		do
			@(negedge clk);
		while (!(exp_q.size() == 0 && !rda && !wr_seen && (rst || (iocs && iorw))));
	endtask

	task automatic run_record(input int i);
		byte_t ch;
		case (rec_kind[i])
			"R": begin
				wait_idle();
				@(posedge clk);
				#2;
				rst    = 1'b1;
				br_cfg = rec_a[i][1:0];
				exp_q.push_back({IO_DIV_LO, rec_b[i][7:0]});
				exp_q.push_back({IO_DIV_HI, rec_c[i][7:0]});
				repeat (4) @(posedge clk);
				#2;
				rst = 1'b0;
			end
			"P": begin
				repeat (rec_b[i]) begin
					@(posedge clk);
					#2;
					probe       = rec_a[i];
					probe_valid = 1'b1;
					@(posedge clk);
					#2;
					probe_valid = 1'b0;
				end
			end
			"C": begin
				@(posedge clk);
				#2;
				cmd_byte  = rec_a[i][7:0];
				cmd_valid = 1'b1;
				@(posedge clk);
				#2;
				cmd_valid = 1'b0;
			end
			default: begin
				for (int r = 0; r < rec_b[i]; r++) begin
					for (int j = 0; j < rec_txt[i].len(); j++) begin
						ch = rec_txt[i][j];
						exp_q.push_back({rec_a[i][1:0], (ch == "_") ? 8'h20 : ch});
					end
				end
			end
		endcase
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Write checker and timeout
	////////////////////////////////////////////////////////////////////////////

	always @(negedge clk) begin
		cycles++;
		if (limit > 0 && cycles > limit) begin
			$display("Timeout after %0d cycles, %0d writes still expected", cycles, exp_q.size());
			abort_run();
		end
		if (iocs && !iorw)
			check_value("db_drive", {7'b0, db_drive}, 8'h01);
		if (wr_seen) begin
			if (exp_q.size() == 0) begin
				$display("Extra bus write of %h to address %0d at %0t ns",
					wr_data, wr_addr, $time);
				abort_run();
			end else begin
				check_value("ioaddr", {6'b0, wr_addr}, {6'b0, exp_q[0][9:8]});
				check_value("db_wr_data", wr_data, exp_q[0][7:0]);
				void'(exp_q.pop_front());
			end
		end
	end

	initial begin
		rst         = 1'b1;
		br_cfg      = 2'd0;
		probe       = '0;
		probe_valid = 1'b0;
		cmd_valid   = 1'b0;
		cmd_byte    = 8'h00;
		load_records();
		for (int i = 0; i < rec_kind.size(); i++)
			run_record(i);
		wait_idle();
		$display("Result: PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// File: sim/spart_stimulus.txt
# R br_cfg div_lo div_hi | P word count | C cmd_byte | X addr text count
# Hex fields except counts, an underscore in text stands for a space
R 1 80 25
R 2 00 4B
R 3 00 96
R 0 C0 12
C 32
X 0 1_ 1
C 31
X 0 0_ 1
C 31
X 0 F_ 1
C 78
C 32
X 0 0_ 1
P DEADBEEF 1
P 0123ABCD 1
P 80000001 1
P 00C0FFEE 1
P 7F3A9C45 1
C 20
X 0 DEADBEEF_ 1
X 0 0123ABCD_ 1
X 0 80000001_ 1
X 0 00C0FFEE_ 1
X 0 7F3A9C45_ 1
X 0 00000000_ 11
C 32
X 0 0_ 1
R 2 00 4B
P A5C3E1F7 16
P 12345678 1
C 20
X 0 A5C3E1F7_ 16
C 31
X 0 E_ 1

// File: all.f
+incdir+src
src/mon_pkg.sv
src/trace_buffer.sv
src/hex_serializer.sv
src/monitor_fsm.sv
src/spart_driver.sv
sim/spart_bus_model.sv
sim/tb_spart_driver.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_spart_driver
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -Wno-fatal
PASS_MSG  := Result: PASSED
SIM_BIN   := $(BUILD_DIR)/V$(TOP)
SOURCES   := $(wildcard src/*.sv src/*.svh sim/*.sv sim/*.txt)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check for the pass message"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
